// ==== vred_pkg.sv ====
/*
 * Vector reduction shared definitions.
 * Vector geometry, element width and operation encodings, the
 * request, inter-stage node and response structs, plus the small
 * helpers that every pipeline stage relies on.
 */
package vred_pkg;

    localparam int VLEN       = 128;
    localparam int NUM_LANES  = VLEN / 8;           // Slots at the narrowest width
    localparam int NUM_STAGES = $clog2(NUM_LANES);
    localparam int SCALAR_W   = 64;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_e;

    typedef enum logic [1:0] {
        RED_SUM,
        RED_AND,
        RED_OR,
        RED_XOR
    } red_op_e;

    typedef struct packed {
        logic                  valid;
        red_op_e               op;
        sew_e                  sew;
        logic [SCALAR_W-1:0]   scalar;
        logic [VLEN-1:0]       data;
        logic [NUM_LANES-1:0]  mask;      // Bit i belongs to slot i at the current width
    } red_req_t;

    typedef struct packed {
        logic                  valid;
        red_op_e               op;
        sew_e                  sew;
        logic [SCALAR_W-1:0]   scalar;
        logic [VLEN-1:0]       data;      // Partially reduced vector
        logic [NUM_LANES-1:0]  mask;
    } red_node_t;

    typedef struct packed {
        logic                  valid;
        logic [SCALAR_W-1:0]   result;
    } red_resp_t;

    // Number of elements in a full vector for the given width
    function automatic int unsigned num_elems(sew_e sew);
        return NUM_LANES >> int'(sew);
    endfunction

    // Ones in the low element-width bits
    function automatic logic [SCALAR_W-1:0] sew_mask(sew_e sew);
        return {SCALAR_W{1'b1}} >> (SCALAR_W - (8 << int'(sew)));
    endfunction

    // Caller truncates to the element width, which makes the sum wrap
    function automatic logic [SCALAR_W-1:0] red_apply(red_op_e op,
                                                      logic [SCALAR_W-1:0] a,
                                                      logic [SCALAR_W-1:0] b);
        case (op)
            RED_SUM: return a + b;
            RED_AND: return a & b;
            RED_OR:  return a | b;
            default: return a ^ b;
        endcase
    endfunction

endpackage

// ==== vred_feed_stage.sv ====
/*
 * Reduction feed stage.
 * Registers each incoming request as the first pipeline node and
 * drops mask bits that lie beyond the element count of its width.
 */
module vred_feed_stage (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  vred_pkg::red_req_t   req_i,
    output vred_pkg::red_node_t  node_o
);

    logic [vred_pkg::NUM_LANES-1:0] keep_mask;
    vred_pkg::red_node_t            node_d;
    vred_pkg::red_node_t            node_q;

    always_comb begin
        for (int i = 0; i < vred_pkg::NUM_LANES; i++) begin
            keep_mask[i] = (i < vred_pkg::num_elems(req_i.sew));   // Slot exists at this width
        end
    end

    always_comb begin
        node_d.valid  = req_i.valid;
        node_d.op     = req_i.op;
        node_d.sew    = req_i.sew;
        node_d.scalar = req_i.scalar;
        node_d.data   = req_i.data;
        node_d.mask   = req_i.mask & keep_mask;
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            node_q <= '0;
        end else begin
            node_q <= node_d;
        end
    end

    assign node_o = node_q;

    // Width and operation decode further down the tree depends on these
    a_req_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        req_i.valid |-> !$isunknown({req_i.sew, req_i.op})
    ) else $error("request with unknown width or operation");

endmodule

// ==== vred_tree_stage.sv ====
/*
 * Reduction tree level.
 * Pairs adjacent live elements under the mask and combines them with
 * the requested operation, halving the live element count. Once one
 * element or fewer is left, the node is passed on unchanged.
 */
module vred_tree_stage #(
    parameter int STAGE_IDX = 0
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  vred_pkg::red_node_t  node_i,
    output vred_pkg::red_node_t  node_o
);

    logic [vred_pkg::VLEN-1:0]      cand_data [4];    // One candidate per element width
    logic [vred_pkg::NUM_LANES-1:0] cand_mask [4];
    vred_pkg::red_node_t            node_d;
    vred_pkg::red_node_t            node_q;
    int unsigned                    surv_slots;

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int EW   = 8 << s;
        localparam int LIVE = (vred_pkg::VLEN / EW) >> STAGE_IDX;

        if (LIVE >= 2) begin : g_pair
            always_comb begin
                logic [vred_pkg::SCALAR_W-1:0] a;
                logic [vred_pkg::SCALAR_W-1:0] b;
                logic [vred_pkg::SCALAR_W-1:0] res;

                cand_data[s] = '0;                       // Slots above the pairs stay clear
                cand_mask[s] = '0;
                for (int j = 0; j < LIVE / 2; j++) begin
                    a          = '0;
                    b          = '0;
                    a[EW-1:0]  = node_i.data[2*j*EW +: EW];
                    b[EW-1:0]  = node_i.data[(2*j+1)*EW +: EW];
                    res        = vred_pkg::red_apply(node_i.op, a, b);
                    case ({node_i.mask[2*j+1], node_i.mask[2*j]})
                        2'b00: begin
                            cand_mask[s][j] = 1'b0;
                        end
                        2'b01: begin
                            cand_data[s][j*EW +: EW] = a[EW-1:0];
                            cand_mask[s][j]          = 1'b1;
                        end
                        2'b10: begin
                            cand_data[s][j*EW +: EW] = b[EW-1:0];
                            cand_mask[s][j]          = 1'b1;
                        end
                        default: begin
                            cand_data[s][j*EW +: EW] = res[EW-1:0];   // Truncation wraps the sum
                            cand_mask[s][j]          = 1'b1;
                        end
                    endcase
                end
            end
        end else begin : g_pass
            assign cand_data[s] = node_i.data;
            assign cand_mask[s] = node_i.mask;
        end
    end

    always_comb begin
        node_d.valid  = node_i.valid;
        node_d.op     = node_i.op;
        node_d.sew    = node_i.sew;
        node_d.scalar = node_i.scalar;
        node_d.data   = cand_data[node_i.sew];
        node_d.mask   = cand_mask[node_i.sew];
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            node_q <= '0;
        end else begin
            node_q <= node_d;
        end
    end

    assign node_o = node_q;

    // Slots still holding data after this level
    always_comb begin
        surv_slots = vred_pkg::num_elems(node_o.sew) >> (STAGE_IDX + 1);
        if (surv_slots == 0) begin
            surv_slots = 1;
        end
    end

    // Relies on the feed stage having trimmed the mask to the element count
    a_mask_trimmed: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        node_o.valid |-> ((node_o.mask >> surv_slots) == '0)
    ) else $error("mask bit set above surviving slots at level %0d", STAGE_IDX);

endmodule

// ==== vred_drain_stage.sv ====
/*
 * Reduction drain stage.
 * Folds the surviving tree element into the scalar operand, falls
 * back to the scalar alone when every element was masked off, and
 * registers the zero-extended result.
 */
module vred_drain_stage (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  vred_pkg::red_node_t  node_i,
    output vred_pkg::red_resp_t  resp_o
);

    logic [vred_pkg::SCALAR_W-1:0] width_mask;
    logic [vred_pkg::SCALAR_W-1:0] slot0;
    logic [vred_pkg::SCALAR_W-1:0] scalar_lo;
    logic [vred_pkg::SCALAR_W-1:0] combined;
    vred_pkg::red_resp_t           resp_d;
    vred_pkg::red_resp_t           resp_q;

    always_comb begin
        width_mask = vred_pkg::sew_mask(node_i.sew);
        slot0      = node_i.data[vred_pkg::SCALAR_W-1:0] & width_mask;
        scalar_lo  = node_i.scalar & width_mask;
        combined   = vred_pkg::red_apply(node_i.op, slot0, scalar_lo) & width_mask;
    end

    always_comb begin
        resp_d.valid = node_i.valid;
        if (node_i.mask[0]) begin
            resp_d.result = combined;
        end else begin
            resp_d.result = scalar_lo;          // Empty mask gives the scalar alone
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            resp_q <= '0;
        end else begin
            resp_q <= resp_d;
        end
    end

    assign resp_o = resp_q;

    // Tree levels leave nothing above slot zero's element width
    a_slot0_clear: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        node_i.valid |-> ((node_i.data[vred_pkg::SCALAR_W-1:0] & ~width_mask) == '0)
    ) else $error("slot zero has bits set above the element width");

endmodule

// ==== vred_top.sv ====
/*
 * Masked vector reduction unit.
 * Six-cycle pipeline: feed stage, a tree of halving levels and a
 * drain stage that merges the scalar operand. One request per cycle.
 */
module vred_top (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  vred_pkg::red_req_t   req_i,
    output vred_pkg::red_resp_t  resp_o
);

    vred_pkg::red_node_t node [0:vred_pkg::NUM_STAGES];   // Node k feeds tree level k

    vred_feed_stage u_feed (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (req_i),
        .node_o (node[0])
    );

    for (genvar k = 0; k < vred_pkg::NUM_STAGES; k++) begin : g_tree
        vred_tree_stage #(
            .STAGE_IDX (k)
        ) u_tree (
            .clk_i  (clk_i),
            .rstn_i (rstn_i),
            .node_i (node[k]),
            .node_o (node[k+1])
        );
    end

    vred_drain_stage u_drain (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .node_i (node[vred_pkg::NUM_STAGES]),
        .resp_o (resp_o)
    );

endmodule

// ==== tb_vred_cases.svh ====
/*
 * Directed cases for the reduction unit testbench.
 * Columns: operation, element width, vector, mask, scalar, expected result.
 */
typedef struct packed {
    vred_pkg::red_op_e                op;
    vred_pkg::sew_e                   sew;
    logic [vred_pkg::VLEN-1:0]        data;
    logic [vred_pkg::NUM_LANES-1:0]   mask;
    logic [vred_pkg::SCALAR_W-1:0]    scalar;
    logic [vred_pkg::SCALAR_W-1:0]    expected;
} case_row_t;

localparam int NUM_CASES = 16;

localparam case_row_t CASE_TBL [NUM_CASES] = '{
    '{vred_pkg::RED_SUM, vred_pkg::SEW_8,  128'hF1F1F1F1_F1F1F1F1_F1F1F1F1_F1F1F1F1,
      16'hFFFF, 64'h1234_5678_9ABC_DEF5, 64'h0000_0000_0000_0005},     // Sum wraps
    '{vred_pkg::RED_SUM, vred_pkg::SEW_16, 128'h80018001_80018001_80018001_80018001,
      16'hFFFF, 64'hAAAA_BBBB_CCCC_FFFF, 64'h0000_0000_0000_0007},
    '{vred_pkg::RED_SUM, vred_pkg::SEW_32, 128'h80000001_80000001_80000001_80000001,
      16'hFFFF, 64'h1111_2222_FFFF_FFFE, 64'h0000_0000_0000_0002},
    '{vred_pkg::RED_SUM, vred_pkg::SEW_64, 128'h80000000_00000003_80000000_00000003,
      16'hFFFF, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0005},
    '{vred_pkg::RED_AND, vred_pkg::SEW_8,  128'hFFFFFFFF_FFFFFF7E_FFFFFFFF_FFFFFFFF,
      16'hFFFF, 64'h0000_0000_0000_00F3, 64'h0000_0000_0000_0072},     // Bitwise ops
    '{vred_pkg::RED_OR,  vred_pkg::SEW_16, 128'h80000040_00200010_00080004_00020001,
      16'hFFFF, 64'hFFFF_FFFF_FFFF_0100, 64'h0000_0000_0000_817F},
    '{vred_pkg::RED_XOR, vred_pkg::SEW_32, 128'h0F0F0F0F_FFFF0000_12345678_12345678,
      16'hFFFF, 64'h9999_9999_0000_FFFF, 64'h0000_0000_F0F0_F0F0},
    '{vred_pkg::RED_XOR, vred_pkg::SEW_64, 128'h55555555_55555555_AAAAAAAA_AAAAAAAA,
      16'h0003, 64'h0F0F_0F0F_0F0F_0F0F, 64'hF0F0_F0F0_F0F0_F0F0},
    '{vred_pkg::RED_SUM, vred_pkg::SEW_8,  128'h0F0E0D0C_0B0A0908_07060504_03020100,
      16'h8102, 64'h0000_0000_0000_0100, 64'h0000_0000_0000_0018},     // Partial masks
    '{vred_pkg::RED_AND, vred_pkg::SEW_16, 128'h00000000_00000000_00003FFF_0000F0F3,
      16'hFF05, 64'h0000_0000_0000_FFF1, 64'h0000_0000_0000_30F1},
    '{vred_pkg::RED_OR,  vred_pkg::SEW_32, 128'h00001000_FFFFFFFF_FFFFFFFF_FFFFFFFF,
      16'hFFF8, 64'hFFFF_FFFF_0000_0001, 64'h0000_0000_0000_1001},
    '{vred_pkg::RED_XOR, vred_pkg::SEW_64, 128'h01234567_89ABCDEF_FFFFFFFF_FFFFFFFF,
      16'h0002, 64'h0000_0000_FFFF_FFFF, 64'h0123_4567_7654_3210},
    '{vred_pkg::RED_SUM, vred_pkg::SEW_8,  128'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF,
      16'h0000, 64'hDEAD_BEEF_CAFE_F00D, 64'h0000_0000_0000_000D},     // Empty masks
    '{vred_pkg::RED_AND, vred_pkg::SEW_16, 128'h00000000_00000000_00000000_00000000,
      16'hFF00, 64'hDEAD_BEEF_CAFE_F00D, 64'h0000_0000_0000_F00D},
    '{vred_pkg::RED_OR,  vred_pkg::SEW_32, 128'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF,
      16'h0000, 64'hDEAD_BEEF_CAFE_F00D, 64'h0000_0000_CAFE_F00D},
    '{vred_pkg::RED_XOR, vred_pkg::SEW_64, 128'h00000000_00000000_00000000_00000000,
      16'hFFFC, 64'hDEAD_BEEF_CAFE_F00D, 64'hDEAD_BEEF_CAFE_F00D}
};

// ==== tb_vred_top.sv ====
/*
 * Testbench for the masked vector reduction unit.
 * Runs directed table cases, then a back-to-back random stream that
 * is checked against a reference model for value and 6-cycle latency.
 */
module tb_vred_top;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 8;
    localparam int LATENCY    = 6;
    localparam int NUM_STREAM = 40;

    `include "tb_vred_cases.svh"

    localparam int WATCHDOG_T = (NUM_CASES + NUM_STREAM + 20) * LATENCY * CLK_PERIOD;

    logic                clk;
    logic                rstn;
    vred_pkg::red_req_t  req;
    vred_pkg::red_resp_t resp;

    int          errors   = 0;
    int          checks   = 0;
    int          edge_cnt = 0;                 // Rising edges seen so far
    integer      seed     = 15;
    logic [63:0] exp_q [$];
    int          edge_q [$];                   // Edge count when each request was driven

    vred_top DUT (
        .clk_i  (clk),
        .rstn_i (rstn),
        .req_i  (req),
        .resp_o (resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    // Independent model of the reduction rules
    function automatic logic [63:0] ref_reduce(input vred_pkg::red_op_e op,
                                               input vred_pkg::sew_e sew,
                                               input logic [127:0] data,
                                               input logic [15:0] mask,
                                               input logic [63:0] scalar);
        int           ew;
        logic [63:0]  wmask;
        logic [127:0] shifted;
        logic [63:0]  acc;
        logic [63:0]  val;
        logic         any;
        case (sew)
            vred_pkg::SEW_8:  ew = 8;
            vred_pkg::SEW_16: ew = 16;
            vred_pkg::SEW_32: ew = 32;
            default:          ew = 64;
        endcase
        wmask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        acc   = '0;
        any   = 1'b0;
        for (int i = 0; i <= 128 / ew; i++) begin
            if (i == 128 / ew) begin
                val = scalar & wmask;              // Scalar joins last
            end else begin
                shifted = data >> (i * ew);
                val     = shifted[63:0] & wmask;
            end
            if (i == 128 / ew || mask[i]) begin
                if (!any) begin
                    acc = val;
                end else begin
                    case (op)
                        vred_pkg::RED_SUM: acc = (acc + val) & wmask;
                        vred_pkg::RED_AND: acc = acc & val;
                        vred_pkg::RED_OR:  acc = acc | val;
                        default:           acc = acc ^ val;
                    endcase
                end
                any = 1'b1;
            end
        end
        return acc;
    endfunction

    task automatic drive_request(input vred_pkg::red_op_e op, input vred_pkg::sew_e sew,
                                 input logic [127:0] data, input logic [15:0] mask,
                                 input logic [63:0] scalar, input logic [63:0] expected);
        @(negedge clk);
        req.valid  = 1'b1;
        req.op     = op;
        req.sew    = sew;
        req.data   = data;
        req.mask   = mask;
        req.scalar = scalar;
        exp_q.push_back(expected);
        edge_q.push_back(edge_cnt);
    endtask

    task automatic drive_idle();
        @(negedge clk);
        req.valid = 1'b0;
    endtask

    task automatic check_idle(input string phase);
        checks++;
        if (resp.valid !== 1'b0 || resp.result !== '0) begin
            $display("CHECK FAILED @%0t: %s, valid=%b result=%h, expected idle output",
                     $time, phase, resp.valid, resp.result);
            errors++;
        end
    endtask

    task automatic wait_responses(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Error: %0d responses still missing after %0d cycles",
                     exp_q.size(), max_cycles);
            errors++;
            exp_q.delete();
            edge_q.delete();
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge clk) begin : monitor
        logic [63:0] expected;
        int          issued;
        if (rstn && resp.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Error: response at time %0t with no request outstanding", $time);
                errors++;
            end else begin
                expected = exp_q.pop_front();
                issued   = edge_q.pop_front();
                checks++;
                if (resp.result !== expected) begin
                    $display("CHECK FAILED @%0t: result %h, expected %h",
                             $time, resp.result, expected);
                    errors++;
                end
                if (edge_cnt - issued != LATENCY) begin
                    $display("CHECK FAILED @%0t: latency %0d cycles, expected %0d",
                             $time, edge_cnt - issued, LATENCY);
                    errors++;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0]  rnd;
        logic [127:0] data;
        logic [63:0]  scalar;
        logic [15:0]  mask;
        req  = '0;
        rstn = 1'b0;
        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_idle("during reset");
        end
        rstn = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle("after reset");
        end

        for (int r = 0; r < NUM_CASES; r++) begin
            drive_request(CASE_TBL[r].op, CASE_TBL[r].sew, CASE_TBL[r].data,
                          CASE_TBL[r].mask, CASE_TBL[r].scalar, CASE_TBL[r].expected);
            drive_idle();
            wait_responses(2 * LATENCY);
        end

        for (int n = 0; n < NUM_STREAM; n++) begin
            rnd    = $random(seed);
            data   = {$random(seed), $random(seed), $random(seed), $random(seed)};
            scalar = {$random(seed), $random(seed)};
            mask   = (rnd[6:4] == 3'd0) ? 16'h0000 : rnd[31:16];   // Some empty masks
            drive_request(vred_pkg::red_op_e'(rnd[1:0]), vred_pkg::sew_e'(rnd[3:2]),
                          data, mask, scalar,
                          ref_reduce(vred_pkg::red_op_e'(rnd[1:0]),
                                     vred_pkg::sew_e'(rnd[3:2]), data, mask, scalar));
        end
        drive_idle();
        wait_responses(4 * LATENCY);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_T);
        $display("Timeout: simulation did not finish within %0d time units", WATCHDOG_T);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
vred_pkg.sv
vred_feed_stage.sv
vred_tree_stage.sv
vred_drain_stage.sv
vred_top.sv
tb_vred_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the reduction unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_vred_top \
    -f compile.f \
    -Mdir obj_dir \
    -o sim_vred

./obj_dir/sim_vred | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
